// File: Bender.yml
package:
  name: mem_wr_tlp_map

sources:
  - mem_wr_pkg.sv
  - wr_beat_decode.sv
  - wr_tlp_build.sv
  - wr_rsp_restore.sv
  - mem_wr_tlp_map.sv
  - target: test
    files:
      - mem_wr_tlp_map_asserts.sv
      - tb_mem_wr_tlp_map.sv

// File: mem_wr_pkg.sv
/*
 * Shared widths, user flag positions, vector typedefs and packed structs
 * for the Avalon write to TLP write request mapper
 */

package mem_wr_pkg;

    // ========================================
    // Widths
    // ========================================

    localparam int LINE_BYTES      = 64;
    localparam int LINE_ADDR_WIDTH = 32;
    localparam int BURST_CNT_WIDTH = 3;
    localparam int USER_WIDTH      = 16;
    localparam int TAG_WIDTH       = 12;
    localparam int NUM_INTERRUPTS  = 4;

    // Avalon user bit positions of the request flags
    localparam int UFLAG_NO_REPLY  = 0;
    localparam int UFLAG_FENCE     = 1;
    localparam int UFLAG_INTERRUPT = 2;

    // ========================================
    // Vector types
    // ========================================

    typedef logic [LINE_BYTES*8-1:0]                  t_line_data;
    typedef logic [LINE_BYTES-1:0]                    t_byte_mask;
    typedef logic [$clog2(LINE_BYTES)-1:0]            t_byte_idx;
    typedef logic [$clog2(LINE_BYTES):0]              t_byte_len;
    typedef logic [LINE_ADDR_WIDTH-1:0]               t_line_addr;
    typedef logic [LINE_ADDR_WIDTH+$clog2(LINE_BYTES)-1:0] t_byte_addr;
    typedef logic [BURST_CNT_WIDTH-1:0]               t_burst_cnt;
    typedef logic [USER_WIDTH-1:0]                    t_user;
    typedef logic [TAG_WIDTH-1:0]                     t_tag;
    typedef logic [$clog2(NUM_INTERRUPTS)-1:0]        t_intr_idx;

    // ========================================
    // Bundles
    // ========================================

    // One Avalon write beat as seen on the bus
    typedef struct packed {
        t_line_addr address;
        t_burst_cnt burstcount;
        t_line_data writedata;
        t_byte_mask byteenable;
        t_user      user;
    } t_avmm_wr_beat;

    // Beat plus what the decode stage found in it
    typedef struct packed {
        t_avmm_wr_beat beat;
        t_byte_idx     byte_start;
        t_byte_idx     byte_end;
        logic          is_fence;
        logic          is_interrupt;
    } t_wr_decoded;

    typedef struct packed {
        logic       sop;
        logic       eop;
        logic       is_fence;
        logic       is_interrupt;
        logic       enable_byte_range;
        t_byte_idx  byte_start_idx;
        t_byte_len  byte_len;
        t_burst_cnt line_count;
        t_byte_addr addr;
        t_tag       tag;
    } t_tlp_wr_hdr;

    typedef struct packed {
        t_tlp_wr_hdr hdr;
        t_line_data  payload;
    } t_tlp_wr_req;

    // Write completion; the tag is the interrupt index for interrupts
    typedef struct packed {
        t_tag tag;
        logic is_interrupt;
    } t_tlp_wr_rsp;

    typedef struct packed {
        t_intr_idx intr_idx;
        t_tag      rob_idx;
    } t_intr_save;

endpackage

// File: mem_wr_tlp_map.sv
/*
 * Avalon write side to TLP write request mapper
 * Beat decode, header build and response restore
 */

`timescale 1ns/1ps

module mem_wr_tlp_map #(
    parameter int ROB_IDX_START = 4
) (
    input  logic                      clk,
    input  logic                      rst_n,

    // Avalon write beats
    input  logic                      wr_write,
    input  mem_wr_pkg::t_avmm_wr_beat wr_beat,
    output logic                      wr_waitrequest,

    // TLP write requests
    output logic                      req_valid,
    output mem_wr_pkg::t_tlp_wr_req   req,
    input  logic                      req_ready,

    // Write completions
    input  logic                      rsp_valid,
    input  mem_wr_pkg::t_tlp_wr_rsp   rsp,

    // Avalon write responses
    output logic                      wr_rsp_valid,
    output mem_wr_pkg::t_user         wr_rsp_user
);

    import mem_wr_pkg::*;

    logic        beat_ready;
    logic        dec_valid;
    logic        dec_ready;
    t_wr_decoded dec;
    logic        intr_save_valid;
    t_intr_save  intr_save;

    assign wr_waitrequest = !beat_ready;

    // ========================================
    // Request path
    // ========================================

    wr_beat_decode #(
        .ROB_IDX_START (ROB_IDX_START)
    ) u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .beat_valid (wr_write),
        .beat       (wr_beat),
        .beat_ready (beat_ready),
        .dec_valid  (dec_valid),
        .dec        (dec),
        .dec_ready  (dec_ready)
    );

    wr_tlp_build #(
        .ROB_IDX_START (ROB_IDX_START)
    ) u_build (
        .clk             (clk),
        .rst_n           (rst_n),
        .dec_valid       (dec_valid),
        .dec             (dec),
        .dec_ready       (dec_ready),
        .req_valid       (req_valid),
        .req             (req),
        .req_ready       (req_ready),
        .intr_save_valid (intr_save_valid),
        .intr_save       (intr_save)
    );

    // ========================================
    // Response path
    // ========================================

    wr_rsp_restore #(
        .ROB_IDX_START (ROB_IDX_START)
    ) u_restore (
        .clk             (clk),
        .rst_n           (rst_n),
        .intr_save_valid (intr_save_valid),
        .intr_save       (intr_save),
        .rsp_valid       (rsp_valid),
        .rsp             (rsp),
        .wr_rsp_valid    (wr_rsp_valid),
        .wr_rsp_user     (wr_rsp_user)
    );

endmodule

// File: mem_wr_tlp_map_asserts.sv
/*
 * Protocol assertions for the mapper top level
 * Request stability under stall, quiet outputs after reset
 */

`timescale 1ns/1ps

module mem_wr_tlp_map_asserts (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    req_valid,
    input mem_wr_pkg::t_tlp_wr_req req,
    input logic                    req_ready,
    input logic                    wr_waitrequest,
    input logic                    wr_rsp_valid
);

    int fail_cnt = 0;

    // A stalled request holds until it transfers
    req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid && !req_ready |=> req_valid && $stable(req))
    else
    begin
        fail_cnt++;
        $error("request changed or dropped while stalled");
    end

    // First cycle out of reset
    reset_quiet: assert property (@(posedge clk)
        $rose(rst_n) |-> !req_valid && !wr_waitrequest && !wr_rsp_valid)
    else
    begin
        fail_cnt++;
        $error("control output high in the first cycle after reset");
    end

endmodule

bind mem_wr_tlp_map mem_wr_tlp_map_asserts u_asserts (.*);

// File: tb.f
mem_wr_pkg.sv
wr_beat_decode.sv
wr_tlp_build.sv
wr_rsp_restore.sv
mem_wr_tlp_map.sv
mem_wr_tlp_map_asserts.sv
tb_mem_wr_tlp_map.sv

// File: tb_mem_wr_tlp_map.sv
/*
 * Testbench for the Avalon write to TLP write request mapper
 * Directed and random write beats, reference request queue,
 * completion replay and the closing report
 */

`timescale 1ns/1ps

module tb_mem_wr_tlp_map;

    import mem_wr_pkg::*;

    localparam int ROB_IDX_START = 4;
    localparam int MAX_CYCLES    = 2000;

    logic          clk;
    logic          rst_n;
    logic          wr_write;
    t_avmm_wr_beat wr_beat;
    logic          wr_waitrequest;
    logic          req_valid;
    t_tlp_wr_req   req;
    logic          req_ready;
    logic          rsp_valid;
    t_tlp_wr_rsp   rsp;
    logic          wr_rsp_valid;
    t_user         wr_rsp_user;

    integer        seed = 32'h49ed_f1cd;
    logic [31:0]   ready_rnd;
    int            errors = 0;
    int            cycles = 0;
    int            n_sent = 0;
    int            n_seen = 0;
    int            burst_pos = 0;
    int            burst_len = 1;
    t_tlp_wr_req   exp_q [$];
    t_tag          intr_rob_ref [NUM_INTERRUPTS];

    mem_wr_tlp_map #(
        .ROB_IDX_START (ROB_IDX_START)
    ) dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .wr_write       (wr_write),
        .wr_beat        (wr_beat),
        .wr_waitrequest (wr_waitrequest),
        .req_valid      (req_valid),
        .req            (req),
        .req_ready      (req_ready),
        .rsp_valid      (rsp_valid),
        .rsp            (rsp),
        .wr_rsp_valid   (wr_rsp_valid),
        .wr_rsp_user    (wr_rsp_user)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= MAX_CYCLES)
        begin
            $display("Run timed out after %0d cycles", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    // Random back-pressure, ready about 70% of the time
    always @(posedge clk)
    begin
        ready_rnd = $random(seed);
        req_ready <= (ready_rnd[3:0] < 4'd11);
    end

    // ========================================
    // Reference model
    // ========================================

    function automatic int lowest_set(t_byte_mask m);
        for (int i = 0; i < LINE_BYTES; i++)
            if (m[i])
                return i;
        return 0;
    endfunction

    function automatic int highest_set(t_byte_mask m);
        for (int i = LINE_BYTES - 1; i >= 0; i--)
            if (m[i])
                return i;
        return LINE_BYTES - 1;
    endfunction

    function automatic t_tlp_wr_req expect_req(t_avmm_wr_beat b, logic sop, logic eop);
        t_tlp_wr_req r;
        logic        fence;
        logic        intr;
        r           = '0;
        fence       = b.user[UFLAG_FENCE];
        intr        = b.user[UFLAG_INTERRUPT];
        r.hdr.sop   = sop;
        r.hdr.eop   = eop;
        r.payload   = b.writedata;
        if (sop)
        begin
            r.hdr.is_fence     = fence;
            r.hdr.is_interrupt = intr;
            r.hdr.line_count   = b.burstcount;
            r.hdr.addr         = t_byte_addr'(b.address) * LINE_BYTES;
            // Interrupts carry the vector number instead of the ROB index
            r.hdr.tag = intr ? t_tag'(b.address[1:0]) : t_tag'(b.user >> ROB_IDX_START);
            if ((!b.byteenable[0] || !b.byteenable[LINE_BYTES-1]) &&
                b.burstcount == 1 && !fence && !intr)
            begin
                r.hdr.enable_byte_range = 1'b1;
                r.hdr.byte_start_idx    = t_byte_idx'(lowest_set(b.byteenable));
                r.hdr.byte_len = t_byte_len'(highest_set(b.byteenable) -
                                             lowest_set(b.byteenable) + 1);
            end
        end
        return r;
    endfunction

    task automatic report_mismatch(string sig, logic [511:0] exp, logic [511:0] got);
        $display("ERR t=%0t %s expected %0h got %0h", $time, sig, exp, got);
        errors++;
    endtask

    // Checks run on the falling edge, away from the driving edge
    always @(negedge clk)
    begin
        t_tlp_wr_req exp;
        t_tag        rob;
        t_user       exp_user;
        if (rst_n)
        begin
            assert (req_valid === (exp_q.size() != 0))
                else report_mismatch("req_valid", exp_q.size() != 0, req_valid);
            assert (wr_waitrequest === (exp_q.size() != 0 && !req_ready))
                else report_mismatch("wr_waitrequest", exp_q.size() != 0 && !req_ready,
                                     wr_waitrequest);
            assert (wr_rsp_valid === rsp_valid)
                else report_mismatch("wr_rsp_valid", rsp_valid, wr_rsp_valid);
            if (req_valid && req_ready && exp_q.size() != 0)
            begin
                exp = exp_q.pop_front();
                assert (req.hdr === exp.hdr)
                    else report_mismatch("req.hdr", exp.hdr, req.hdr);
                assert (req.payload === exp.payload)
                    else report_mismatch("req.payload", exp.payload, req.payload);
                n_seen++;
            end
            if (rsp_valid)
            begin
                rob      = rsp.is_interrupt ? intr_rob_ref[rsp.tag[1:0]] : rsp.tag;
                exp_user = t_user'(rob) << ROB_IDX_START;
                assert (wr_rsp_user === exp_user)
                    else report_mismatch("wr_rsp_user", exp_user, wr_rsp_user);
            end
            if (wr_write && !wr_waitrequest)
            begin
                if (burst_pos == 0)
                    burst_len = (wr_beat.burstcount == 0) ? 1 : int'(wr_beat.burstcount);
                exp_q.push_back(expect_req(wr_beat, burst_pos == 0, burst_pos + 1 == burst_len));
                if (burst_pos == 0 && wr_beat.user[UFLAG_INTERRUPT])
                    intr_rob_ref[wr_beat.address[1:0]] = t_tag'(wr_beat.user >> ROB_IDX_START);
                burst_pos = (burst_pos + 1 == burst_len) ? 0 : burst_pos + 1;
                n_sent++;
            end
        end
    end

    // ========================================
    // Stimulus
    // ========================================

    // Holds the beat until the DUT takes it, returns on the accepting edge
    task automatic drive_beat(t_avmm_wr_beat b);
        logic taken;
        wr_write <= 1'b1;
        wr_beat  <= b;
        do
        begin
            @(negedge clk);
            taken = !wr_waitrequest;
            @(posedge clk);
        end
        while (!taken);
    endtask

    task automatic send_burst(t_line_addr addr, int len, t_user user, t_byte_mask mask);
        t_avmm_wr_beat b;
        for (int i = 0; i < len; i++)
        begin
            b.address    = addr + t_line_addr'(i);
            b.burstcount = t_burst_cnt'(len);
            b.byteenable = mask;
            b.user       = user;
            for (int w = 0; w < LINE_BYTES / 4; w++)
                b.writedata[w*32 +: 32] = $random(seed);
            drive_beat(b);
        end
        wr_write <= 1'b0;
    endtask

    task automatic send_rsp(t_tag tag, logic is_intr);
        rsp_valid <= 1'b1;
        rsp       <= '{tag: tag, is_interrupt: is_intr};
        @(posedge clk);
        rsp_valid <= 1'b0;
    endtask

    initial
    begin
        rst_n     = 1'b0;
        wr_write  = 1'b0;
        wr_beat   = '0;
        req_ready = 1'b0;
        rsp_valid = 1'b0;
        rsp       = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        // Single beats, full and partial masks
        send_burst(32'h0000_1234, 1, 16'h05A0, '1);
        send_burst(32'h0000_2000, 1, 16'h0110, 64'h0000_0FF0_0000_0000);
        send_burst(32'h0000_2001, 1, 16'h0121, 64'h0000_0000_0000_00FF);
        send_burst(32'h0000_2002, 1, 16'h0130, 64'h8000_0000_0000_0000);

        // Bursts, one with a partial mask
        send_burst(32'h0001_0000, 2, 16'h0200, '1);
        send_burst(32'h0001_0010, 3, 16'h0300, 64'h00FF_FFFF_FFFF_FF00);
        send_burst(32'h0001_0020, 4, 16'h0400, '1);

        // Fence with a partial mask, then one interrupt per vector
        send_burst(32'h0002_0000, 1, 16'h0502, 64'h0000_0000_FFFF_0000);
        for (int v = 0; v < NUM_INTERRUPTS; v++)
            send_burst(32'h0003_0000 + v, 1, t_user'(16'h0A04 + (v << 8)), '1);

        repeat (60)
        begin
            logic [31:0] r;
            t_byte_mask  m;
            r = $random(seed);
            m = (r[5:4] == 2'd0) ? {$random(seed), $random(seed)} : '1;
            send_burst($random(seed), 1 + r[7:6],
                       {r[31:20], 1'b0, r[2:0] == 3'd1, r[2:0] == 3'd0, r[3]}, m);
        end

        while (exp_q.size() != 0)
            @(posedge clk);

        send_rsp(12'h123, 1'b0);
        send_rsp(12'hFFF, 1'b0);
        send_rsp(12'h000, 1'b0);
        for (int v = 0; v < NUM_INTERRUPTS; v++)
            send_rsp(t_tag'(v), 1'b1);
        repeat (2) @(posedge clk);

        $display("Errors: %0d value checks, %0d assertion failures, %0d of %0d requests seen",
                 errors, dut0.u_asserts.fail_cnt, n_seen, n_sent);
        if (errors == 0 && dut0.u_asserts.fail_cnt == 0 && n_seen == n_sent)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// File: wr_beat_decode.sv
/*
 * Write beat decode stage. One register slot that accepts Avalon write
 * beats and records the enabled byte range and the fence and interrupt
 * flags for the header build stage
 */

`timescale 1ns/1ps

module wr_beat_decode #(
    parameter int ROB_IDX_START = 4
) (
    input  logic                      clk,
    input  logic                      rst_n,

    input  logic                      beat_valid,
    input  mem_wr_pkg::t_avmm_wr_beat beat,
    output logic                      beat_ready,

    output logic                      dec_valid,
    output mem_wr_pkg::t_wr_decoded   dec,
    input  logic                      dec_ready
);

    import mem_wr_pkg::*;

    logic        full;
    logic        load;
    t_byte_idx   byte_start;
    t_byte_idx   byte_end;
    logic        flag_fence;
    logic        flag_interrupt;

    // ========================================
    // Slot control
    // ========================================

    // Accept when empty or when the held beat leaves this cycle
    assign beat_ready = !full || dec_ready;
    assign load       = beat_valid && beat_ready;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            full <= 1'b0;
        end
        else if (load)
        begin
            full <= 1'b1;
        end
        else if (dec_ready)
        begin
            full <= 1'b0;
        end
    end

    assign dec_valid = full;

    // ========================================
    // Byte range and flags
    // ========================================

    // Lowest and highest enabled byte; an empty mask gives 0 and 63
    always_comb
    begin
        byte_start = '0;
        byte_end   = '1;
        for (int i = LINE_BYTES - 1; i >= 0; i--)
        begin
            if (beat.byteenable[i])
                byte_start = t_byte_idx'(i);
        end
        for (int i = 0; i < LINE_BYTES; i++)
        begin
            if (beat.byteenable[i])
                byte_end = t_byte_idx'(i);
        end
    end

    // Flag bits only exist below the ROB index field
    assign flag_fence     = (UFLAG_FENCE < ROB_IDX_START) && beat.user[UFLAG_FENCE];
    assign flag_interrupt = (UFLAG_INTERRUPT < ROB_IDX_START) &&
                            beat.user[UFLAG_INTERRUPT];

    always_ff @(posedge clk)
    begin
        if (load)
        begin
            dec.beat         <= beat;
            dec.byte_start   <= byte_start;
            dec.byte_end     <= byte_end;
            dec.is_fence     <= flag_fence;
            dec.is_interrupt <= flag_interrupt;
        end
    end

endmodule

// File: wr_rsp_restore.sv
/*
 * Write response restore. Holds the ROB index of each interrupt vector
 * and maps write completions back onto Avalon response user bits
 */

`timescale 1ns/1ps

module wr_rsp_restore #(
    parameter int ROB_IDX_START = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,

    input  logic                   intr_save_valid,
    input  mem_wr_pkg::t_intr_save intr_save,

    input  logic                   rsp_valid,
    input  mem_wr_pkg::t_tlp_wr_rsp rsp,

    output logic                   wr_rsp_valid,
    output mem_wr_pkg::t_user      wr_rsp_user
);

    import mem_wr_pkg::*;

    t_tag intr_rob [NUM_INTERRUPTS];
    t_tag rob_idx;

    // Table entries are written by the request side, ignored while in reset
    always_ff @(posedge clk)
    begin
        if (rst_n && intr_save_valid)
        begin
            intr_rob[intr_save.intr_idx] <= intr_save.rob_idx;
        end
    end

    // Interrupt completions carry the vector, not the ROB index
    assign rob_idx = rsp.is_interrupt ? intr_rob[t_intr_idx'(rsp.tag)] : rsp.tag;

    always_comb
    begin
        wr_rsp_user = t_user'(t_user'(rob_idx) << ROB_IDX_START);
        wr_rsp_user[UFLAG_NO_REPLY]  = 1'b0;
        wr_rsp_user[UFLAG_FENCE]     = 1'b0;
        wr_rsp_user[UFLAG_INTERRUPT] = 1'b0;
    end

    assign wr_rsp_valid = rsp_valid;

endmodule

// File: wr_tlp_build.sv
/*
 * Write request header build. Tracks the position inside each burst,
 * fills the TLP write header on the first beat and reports interrupt
 * requests so their ROB index can be restored on completion
 */

`timescale 1ns/1ps

module wr_tlp_build #(
    parameter int ROB_IDX_START = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic                    dec_valid,
    input  mem_wr_pkg::t_wr_decoded dec,
    output logic                    dec_ready,

    output logic                    req_valid,
    output mem_wr_pkg::t_tlp_wr_req req,
    input  logic                    req_ready,

    output logic                    intr_save_valid,
    output mem_wr_pkg::t_intr_save  intr_save
);

    import mem_wr_pkg::*;

    t_burst_cnt beat_cnt;
    t_burst_cnt burst_len;
    logic       is_sop;
    logic       is_eop;
    logic       xfer;
    logic       partial;
    t_tag       rob_idx;
    t_intr_idx  intr_idx;

    // Pure pass-through flow control, one beat per request
    assign req_valid = dec_valid;
    assign dec_ready = req_ready;
    assign xfer      = req_valid && req_ready;

    // ========================================
    // Burst tracking
    // ========================================

    assign is_sop = (beat_cnt == '0);

    // Burst length comes from the sop beat; later beats may carry anything
    always_comb
    begin
        if (is_sop)
            is_eop = (dec.beat.burstcount <= t_burst_cnt'(1));
        else
            is_eop = (t_burst_cnt'(beat_cnt + 1'b1) == burst_len);
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            beat_cnt  <= '0;
            burst_len <= '0;
        end
        else if (xfer)
        begin
            if (is_sop)
                burst_len <= dec.beat.burstcount;

            if (is_eop)
                beat_cnt <= '0;
            else
                beat_cnt <= t_burst_cnt'(beat_cnt + 1'b1);
        end
    end

    // ========================================
    // Header
    // ========================================

    assign rob_idx  = t_tag'(dec.beat.user >> ROB_IDX_START);
    // Interrupt vector travels in the low line address bits
    assign intr_idx = t_intr_idx'(dec.beat.address);

    // Partial writes only for single-line plain writes
    assign partial = (!dec.beat.byteenable[0] || !dec.beat.byteenable[LINE_BYTES-1]) &&
                     (dec.beat.burstcount == t_burst_cnt'(1)) &&
                     !dec.is_fence && !dec.is_interrupt;

    always_comb
    begin
        req.hdr     = '0;
        req.hdr.sop = is_sop;
        req.hdr.eop = is_eop;

        if (is_sop)
        begin
            req.hdr.is_fence     = dec.is_fence;
            req.hdr.is_interrupt = dec.is_interrupt;
            req.hdr.line_count   = dec.beat.burstcount;
            req.hdr.addr         = {dec.beat.address, t_byte_idx'(0)};
            req.hdr.tag          = dec.is_interrupt ? t_tag'(intr_idx) : rob_idx;

            if (partial)
            begin
                req.hdr.enable_byte_range = 1'b1;
                req.hdr.byte_start_idx    = dec.byte_start;
                req.hdr.byte_len          = t_byte_len'({1'b0, dec.byte_end} -
                                                        {1'b0, dec.byte_start} + 1'b1);
            end
        end

        req.payload = dec.beat.writedata;
    end

    // Restore stage keeps the ROB index of each interrupt vector
    assign intr_save_valid    = xfer && req.hdr.is_interrupt;
    assign intr_save.intr_idx = intr_idx;
    assign intr_save.rob_idx  = rob_idx;

endmodule
